// File: vlog.f
+incdir+source
source/dcache_pkg.sv
source/store_align.sv
source/dcache_array.sv
source/miss_arbiter.sv
source/dcache_mshr.sv
source/dcache_subsystem.sv
verif/dcache_props.sv
verif/dcache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb \
    -f vlog.f

output=$(./obj_dir/Vdcache_tb)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// File: verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_ROWS     = 27;
    localparam int TIMEOUT      = NUM_ROWS * 40 + RESET_CYCLES;

    logic      clock;
    logic      reset;
    logic      load_valid;
    addr_t     load_addr;
    logic      load_hit;
    block_t    load_data;
    logic      store_valid;
    addr_t     store_addr;
    mem_size_t store_size;
    word_t     store_data;
    logic      store_done;
    logic      mem_read_valid;
    line_tag_t mem_read_tag;
    logic      mem_read_accepted;
    mem_tag_t  mem_req_tag;
    block_t    mem_data;
    mem_tag_t  mem_data_tag;
    logic      mem_write_valid;
    line_tag_t mem_write_tag;
    block_t    mem_write_data;

    // Stimulus table
    logic        row_store  [NUM_ROWS];
    addr_t       row_addr   [NUM_ROWS];
    mem_size_t   row_size   [NUM_ROWS];
    word_t       row_data   [NUM_ROWS];
    logic [63:0] row_expect [NUM_ROWS];
    int          row_count;

    // Memory contents, cache truth and request history by line tag
    logic [63:0] ref_mem    [line_tag_t];
    logic [63:0] live_data  [line_tag_t];
    bit          live_dirty [line_tag_t];
    bit          req_open   [line_tag_t];
    bit          fetched    [line_tag_t];

    mem_tag_t    rq_tag  [$];
    line_tag_t   rq_line [$];
    int          rq_due  [$];
    mem_tag_t    next_tag;
    logic [31:0] lfsr_state;
    line_tag_t   cur_line;
    int          cycle;
    int          error_count;
    int          pass_count;
    int          fail_count;

    dcache_subsystem u_dcache_subsystem (.*);

    initial clock = 1'b0;
    always #2 clock = ~clock;

    function automatic logic [63:0] mem_pattern(input line_tag_t line);
        return {line, 3'h5, ~line, 3'h2};
    endfunction

    function automatic logic [63:0] mem_read_line(input line_tag_t line);
        return ref_mem.exists(line) ? ref_mem[line] : mem_pattern(line);
    endfunction

    function automatic logic [63:0] live_value(input line_tag_t line);
        return live_data.exists(line) ? live_data[line] : mem_read_line(line);
    endfunction

    // Taps 32,22,2,1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Byte lanes follow the address; halves ignore bit 0, words ignore bits 1:0
    function automatic logic [63:0] merge_store(input logic [63:0] old, input addr_t addr,
                                                input mem_size_t size, input word_t data);
        logic [63:0] blk;
        int          lane;
        blk  = old;
        lane = addr[2:0];
        case (size)
            BYTE: blk[lane*8 +: 8] = data[7:0];
            HALF: begin
                lane = {addr[2:1], 1'b0};
                blk[lane*8 +: 16] = data[15:0];
            end
            default: begin
                lane = {addr[2], 2'b00};
                blk[lane*8 +: 32] = data;
            end
        endcase
        return blk;
    endfunction

    task automatic add_row(input logic is_store, input addr_t addr, input mem_size_t size,
                           input word_t data);
        row_store[row_count] = is_store;
        row_addr[row_count]  = addr;
        row_size[row_count]  = size;
        row_data[row_count]  = data;
        row_count++;
    endtask

    task automatic build_table();
        logic [63:0] pat;
        pat = mem_pattern(29'h202);
        add_row(0, 32'h1000, WORD, 0);
        add_row(1, 32'h1000, BYTE, 32'h11);
        add_row(1, 32'h1007, BYTE, 32'h22);
        add_row(1, 32'h1003, HALF, 32'h3344);
        add_row(1, 32'h1004, WORD, 32'h5566_7788);
        add_row(0, 32'h1000, WORD, 0);
        add_row(1, 32'h1008, WORD, 32'ha1b2_c3d4);
        add_row(1, 32'h100e, HALF, 32'hbeef);
        add_row(1, 32'h1009, BYTE, 32'h5a);
        add_row(0, 32'h100c, WORD, 0);
        // Same byte as memory holds, so the line stays clean
        add_row(1, 32'h1010, BYTE, {24'h0, pat[7:0]});
        add_row(0, 32'h1010, WORD, 0);
        for (int k = 0; k < 10; k++) begin
            add_row(0, 32'h1018 + k * 8, WORD, 0);
        end
        add_row(0, 32'h1000, WORD, 0);
        add_row(0, 32'h1008, WORD, 0);
        add_row(0, 32'h1010, WORD, 0);
        add_row(1, 32'h1066, DOUBLE, 32'h1234_5678);
        add_row(0, 32'h1060, WORD, 0);
    endtask

    task automatic compute_expect();
        logic [63:0] pred [line_tag_t];
        line_tag_t   line;
        logic [63:0] old;
        for (int i = 0; i < NUM_ROWS; i++) begin
            line = row_addr[i][31:3];
            old  = pred.exists(line) ? pred[line] : mem_pattern(line);
            row_expect[i] = row_store[i] ? merge_store(old, row_addr[i], row_size[i], row_data[i])
                                         : old;
            pred[line] = row_expect[i];
        end
    endtask

    task automatic apply_row(input int i);
        int          waited;
        int          errs_before;
        logic        done;
        logic        first_touch;
        logic [63:0] got;
        line_tag_t   line;
        errs_before = error_count;
        line        = row_addr[i][31:3];
        cur_line    = line;
        first_touch = !fetched.exists(line);
        waited      = 0;
        done        = 1'b0;
        got         = '0;
        load_valid  = !row_store[i];
        load_addr   = row_addr[i];
        store_valid = row_store[i];
        store_addr  = row_addr[i];
        store_size  = row_size[i];
        store_data  = row_data[i];
        while (!done) begin
            @(posedge clock);
            waited++;
            if (row_store[i]) begin
                done = store_done;
            end else begin
                done = load_hit;
                got  = load_data;
            end
            if (first_touch && waited == 1 && done) begin
                $display("Line %h answered before it was ever fetched from memory", line);
                error_count++;
            end
        end
        @(negedge clock);
        load_valid  = 1'b0;
        store_valid = 1'b0;
        if (row_store[i]) begin
            if (row_expect[i] != live_value(line)) begin
                live_dirty[line] = 1'b1;
            end
            live_data[line] = row_expect[i];
        end else if (got != row_expect[i]) begin
            $display("ERROR %0t load_data: expected %h, got %h", $time, row_expect[i], got);
            error_count++;
        end
        if (error_count == errs_before) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d %s addr %h: %s after %0d cycles", i + 1,
                 row_store[i] ? "store" : "load", row_addr[i],
                 (error_count == errs_before) ? "ok" : "failed", waited);
    endtask

    // Run limit
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle > TIMEOUT) begin
            $display("Timeout, the cache stopped answering after %0d cycles", cycle);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Memory model sampled at the rising edge
    always @(posedge clock) begin
        if (reset) begin
            if (mem_data_tag != '0) begin
                req_open.delete(rq_line[0]);
                void'(rq_tag.pop_front());
                void'(rq_line.pop_front());
                void'(rq_due.pop_front());
            end
            if (mem_read_valid && mem_read_accepted) begin
                if (req_open.exists(mem_read_tag)) begin
                    $display("Second read request for line %h while one is open", mem_read_tag);
                    error_count++;
                end
                if (mem_read_tag != cur_line) begin
                    $display("ERROR %0t mem_read_tag: expected %h, got %h",
                             $time, cur_line, mem_read_tag);
                    error_count++;
                end
                req_open[mem_read_tag] = 1'b1;
                fetched[mem_read_tag]  = 1'b1;
                lfsr_state = lfsr_step(lfsr_state);
                rq_due.push_back(cycle + 1 + lfsr_state[0]);
                lfsr_state = lfsr_step(lfsr_state);
                rq_due[$] = rq_due[$] + 2 * lfsr_state[0];
                rq_tag.push_back(mem_req_tag);
                rq_line.push_back(mem_read_tag);
                next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
            end
            if (mem_write_valid) begin
                if (!(live_dirty.exists(mem_write_tag) && live_dirty[mem_write_tag])) begin
                    $display("Writeback of line %h that was never changed", mem_write_tag);
                    error_count++;
                end else if (mem_write_data != live_value(mem_write_tag)) begin
                    $display("ERROR %0t mem_write_data: expected %h, got %h",
                             $time, live_value(mem_write_tag), mem_write_data);
                    error_count++;
                end
                ref_mem[mem_write_tag]    = mem_write_data;
                live_dirty[mem_write_tag] = 1'b0;
            end
        end
    end

    // Memory returns data in order once its latency has passed
    always @(negedge clock) begin
        mem_req_tag = next_tag;
        if (rq_tag.size() > 0 && cycle >= rq_due[0]) begin
            mem_data_tag = rq_tag[0];
            mem_data     = mem_read_line(rq_line[0]);
        end else begin
            mem_data_tag = '0;
            mem_data     = '0;
        end
    end

    initial begin
        reset             = 1'b0;
        load_valid        = 1'b0;
        load_addr         = '0;
        store_valid       = 1'b0;
        store_addr        = '0;
        store_size        = BYTE;
        store_data        = '0;
        mem_read_accepted = 1'b1;
        mem_req_tag       = 4'h1;
        mem_data_tag      = '0;
        mem_data          = '0;
        next_tag          = 4'h1;
        lfsr_state        = 32'h0a12_5ea3;
        cur_line          = '0;
        error_count       = 0;
        pass_count        = 0;
        fail_count        = 0;
        row_count         = 0;
        build_table();
        compute_expect();
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        if (mem_read_valid || mem_write_valid || store_done || load_hit) begin
            $display("Outputs not idle after reset");
            fail_count++;
            error_count++;
        end else begin
            pass_count++;
        end
        $display("test 0 idle after reset: %s", (fail_count == 0) ? "ok" : "failed");
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/dcache_props.sv
`timescale 1ns/1ps

module dcache_props (
    input logic clock,
    input logic reset,
    input logic mem_read_valid,
    input logic mem_write_valid,
    input logic store_valid,
    input logic store_done
);

    // Writeback is a single-cycle pulse out of the eviction register
    write_single_pulse: assert property (
        @(posedge clock) disable iff (!reset)
        mem_write_valid |=> !mem_write_valid
    ) else $error("mem_write_valid held for more than one cycle");

    // Writeback wins over a read request in the same cycle
    read_write_exclusive: assert property (
        @(posedge clock) disable iff (!reset)
        !(mem_read_valid && mem_write_valid)
    ) else $error("mem_read_valid and mem_write_valid high together");

    store_done_needs_valid: assert property (
        @(posedge clock) disable iff (!reset)
        store_done |-> store_valid
    ) else $error("store_done without store_valid");

endmodule

bind dcache_subsystem dcache_props u_dcache_props (
    .clock           (clock),
    .reset           (reset),
    .mem_read_valid  (mem_read_valid),
    .mem_write_valid (mem_write_valid),
    .store_valid     (store_valid),
    .store_done      (store_done)
);

// File: source/dcache_subsystem.sv
`timescale 1ns/1ps

module dcache_subsystem
    import dcache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      load_valid,
    input  addr_t     load_addr,
    output logic      load_hit,
    output block_t    load_data,
    input  logic      store_valid,
    input  addr_t     store_addr,
    input  mem_size_t store_size,
    input  word_t     store_data,
    output logic      store_done,
    output logic      mem_read_valid,
    output line_tag_t mem_read_tag,
    input  logic      mem_read_accepted,
    input  mem_tag_t  mem_req_tag,
    input  block_t    mem_data,
    input  mem_tag_t  mem_data_tag,
    output logic      mem_write_valid,
    output line_tag_t mem_write_tag,
    output block_t    mem_write_data
);

    line_tag_t store_line_tag;
    block_t    store_block;
    byte_en_t  store_byte_en;
    logic      store_hit;
    logic      refill_busy;
    logic      evict_valid;
    line_tag_t evict_tag;
    block_t    evict_data;
    logic      refill_valid;
    line_tag_t refill_tag;
    logic      pending_found;
    line_tag_t miss_tag;
    logic      push_valid;
    mem_tag_t  push_mem_tag;
    line_tag_t push_line_tag;

    store_align u_store_align (
        .store_addr     (store_addr),
        .store_size     (store_size),
        .store_data     (store_data),
        .store_line_tag (store_line_tag),
        .store_block    (store_block),
        .store_byte_en  (store_byte_en)
    );

    dcache_array u_dcache_array (
        .clock          (clock),
        .reset          (reset),
        .load_valid     (load_valid),
        .load_addr      (load_addr),
        .store_valid    (store_valid),
        .store_line_tag (store_line_tag),
        .store_block    (store_block),
        .store_byte_en  (store_byte_en),
        .refill_valid   (refill_valid),
        .refill_tag     (refill_tag),
        .mem_data       (mem_data),
        .load_hit       (load_hit),
        .load_data      (load_data),
        .store_hit      (store_hit),
        .store_done     (store_done),
        .refill_busy    (refill_busy),
        .evict_valid    (evict_valid),
        .evict_tag      (evict_tag),
        .evict_data     (evict_data)
    );

    miss_arbiter u_miss_arbiter (
        .load_valid        (load_valid),
        .load_hit          (load_hit),
        .store_valid       (store_valid),
        .store_hit         (store_hit),
        .pending_found     (pending_found),
        .mem_read_accepted (mem_read_accepted),
        .refill_busy       (refill_busy),
        .load_addr         (load_addr),
        .store_line_tag    (store_line_tag),
        .mem_req_tag       (mem_req_tag),
        .evict_valid       (evict_valid),
        .evict_tag         (evict_tag),
        .evict_data        (evict_data),
        .miss_tag          (miss_tag),
        .mem_read_valid    (mem_read_valid),
        .mem_read_tag      (mem_read_tag),
        .mem_write_valid   (mem_write_valid),
        .mem_write_tag     (mem_write_tag),
        .mem_write_data    (mem_write_data),
        .push_valid        (push_valid),
        .push_mem_tag      (push_mem_tag),
        .push_line_tag     (push_line_tag)
    );

    dcache_mshr u_dcache_mshr (
        .clock         (clock),
        .reset         (reset),
        .push_valid    (push_valid),
        .push_mem_tag  (push_mem_tag),
        .mem_data_tag  (mem_data_tag),
        .push_line_tag (push_line_tag),
        .miss_tag      (miss_tag),
        .pending_found (pending_found),
        .refill_valid  (refill_valid),
        .refill_tag    (refill_tag)
    );

endmodule

// File: source/dcache_mshr.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_mshr
    import dcache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      push_valid,
    input  mem_tag_t  push_mem_tag,
    input  mem_tag_t  mem_data_tag,
    input  line_tag_t push_line_tag,
    input  line_tag_t miss_tag,
    output logic      pending_found,
    output logic      refill_valid,
    output line_tag_t refill_tag
);

    localparam int PTR_BITS = $clog2(`DCACHE_MSHR_DEPTH);

    mshr_entry_t         entries [`DCACHE_MSHR_DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic                pop;
    logic                push;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(`DCACHE_MSHR_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Duplicate search over every live entry
    always_comb begin
        pending_found = 1'b0;
        for (int i = 0; i < `DCACHE_MSHR_DEPTH; i++) begin
            if (entries[i].valid && entries[i].line_tag == miss_tag) begin
                pending_found = 1'b1;
            end
        end
    end

    // Only the oldest request may retire, anything out of order is dropped
    assign pop = (mem_data_tag != '0) && entries[head].valid
                 && (entries[head].mem_tag == mem_data_tag);

    // A full queue refuses the push, the miss stays presented and asks again
    assign push = push_valid && !entries[tail].valid;

    assign refill_valid = pop;
    assign refill_tag   = pop ? entries[head].line_tag : '0;

    always_ff @(posedge clock) begin
        if (!reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < `DCACHE_MSHR_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head                <= next_ptr(head);
            end
            if (push) begin
                entries[tail] <= '{valid: 1'b1, mem_tag: push_mem_tag, line_tag: push_line_tag};
                tail          <= next_ptr(tail);
            end
        end
    end

endmodule

// File: source/miss_arbiter.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module miss_arbiter
    import dcache_pkg::*;
(
    input  logic      load_valid,
    input  logic      load_hit,
    input  logic      store_valid,
    input  logic      store_hit,
    input  logic      pending_found,
    input  logic      mem_read_accepted,
    input  logic      refill_busy,
    input  addr_t     load_addr,
    input  line_tag_t store_line_tag,
    input  mem_tag_t  mem_req_tag,
    input  logic      evict_valid,
    input  line_tag_t evict_tag,
    input  block_t    evict_data,
    output line_tag_t miss_tag,
    output logic      mem_read_valid,
    output line_tag_t mem_read_tag,
    output logic      mem_write_valid,
    output line_tag_t mem_write_tag,
    output block_t    mem_write_data,
    output logic      push_valid,
    output mem_tag_t  push_mem_tag,
    output line_tag_t push_line_tag
);

    logic store_miss;
    logic load_miss;
    logic miss_valid;

    assign store_miss = store_valid && !store_hit;
    assign load_miss  = load_valid && !load_hit;
    assign miss_valid = store_miss || load_miss;

    // Store misses go first
    assign miss_tag = store_miss ? store_line_tag : load_addr[31:`DCACHE_OFFSET_BITS];

    // Dirty victim goes out straight from the eviction register
    assign mem_write_valid = evict_valid;
    assign mem_write_tag   = evict_valid ? evict_tag : '0;
    assign mem_write_data  = evict_valid ? evict_data : '0;

    // Writeback beats a read, and a line already in flight is not asked for again.
    // No read goes out while a refill is being written either.
    assign mem_read_valid = miss_valid && !mem_write_valid && !pending_found && !refill_busy;
    assign mem_read_tag   = mem_read_valid ? miss_tag : '0;

    // Tag zero from memory means the request was not taken
    assign push_valid    = mem_read_valid && mem_read_accepted && (mem_req_tag != '0);
    assign push_mem_tag  = mem_req_tag;
    assign push_line_tag = miss_tag;

endmodule

// File: source/dcache_array.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_array
    import dcache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      load_valid,
    input  addr_t     load_addr,
    input  logic      store_valid,
    input  line_tag_t store_line_tag,
    input  block_t    store_block,
    input  byte_en_t  store_byte_en,
    input  logic      refill_valid,
    input  line_tag_t refill_tag,
    input  block_t    mem_data,
    output logic      load_hit,
    output block_t    load_data,
    output logic      store_hit,
    output logic      store_done,
    output logic      refill_busy,
    output logic      evict_valid,
    output line_tag_t evict_tag,
    output block_t    evict_data
);

    localparam int INDEX_BITS = $clog2(`DCACHE_LINES);
    localparam int LFSR_BITS  = 8;

    cache_line_t           lines [`DCACHE_LINES];
    logic [LFSR_BITS-1:0]  lfsr;
    line_tag_t             load_tag;
    logic [INDEX_BITS-1:0] store_index;
    logic [INDEX_BITS-1:0] free_index;
    logic [INDEX_BITS-1:0] fill_index;
    logic                  free_found;
    block_t                merged_data;
    logic                  merged_dirty;

    assign load_tag = load_addr[31:`DCACHE_OFFSET_BITS];

    // Fully associative lookups
    always_comb begin
        load_hit  = 1'b0;
        load_data = '0;
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            if (load_valid && lines[i].valid && lines[i].tag == load_tag) begin
                load_hit  = 1'b1;
                load_data = lines[i].data;
            end
        end
    end

    always_comb begin
        store_hit   = 1'b0;
        store_index = '0;
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            if (store_valid && lines[i].valid && lines[i].tag == store_line_tag) begin
                store_hit   = 1'b1;
                store_index = INDEX_BITS'(i);
            end
        end
    end

    // Lowest free line wins, otherwise the LFSR picks a victim
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = `DCACHE_LINES - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                free_found = 1'b1;
                free_index = INDEX_BITS'(i);
            end
        end
    end

    assign fill_index = free_found ? free_index : lfsr[INDEX_BITS-1:0];

    // Byte merge, dirty only if the contents really change
    always_comb begin
        merged_data = lines[store_index].data;
        for (int b = 0; b < `DCACHE_BLOCK_BYTES; b++) begin
            if (store_byte_en[b]) begin
                merged_data.bytes[b] = store_block.bytes[b];
            end
        end
        merged_dirty = lines[store_index].dirty || (merged_data != lines[store_index].data);
    end

    // Refill owns the write port this cycle
    assign refill_busy = refill_valid;
    assign store_done  = store_valid && store_hit && !refill_valid;

    // Taps 8,6,5,4
    always_ff @(posedge clock) begin
        if (!reset) begin
            lfsr <= 8'ha5;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `DCACHE_LINES; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else if (refill_valid) begin
            lines[fill_index] <= '{valid: 1'b1, dirty: 1'b0, tag: refill_tag, data: mem_data};
        end else if (store_done) begin
            lines[store_index].data  <= merged_data;
            lines[store_index].dirty <= merged_dirty;
        end
    end

    // Victim is captured before the refill overwrites it
    always_ff @(posedge clock) begin
        if (!reset) begin
            evict_valid <= 1'b0;
        end else begin
            evict_valid <= refill_valid && !free_found && lines[fill_index].dirty;
        end
    end

    always_ff @(posedge clock) begin
        evict_tag  <= lines[fill_index].tag;
        evict_data <= lines[fill_index].data;
    end

endmodule

// File: source/store_align.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module store_align
    import dcache_pkg::*;
(
    input  addr_t     store_addr,
    input  mem_size_t store_size,
    input  word_t     store_data,
    output line_tag_t store_line_tag,
    output block_t    store_block,
    output byte_en_t  store_byte_en
);

    logic [`DCACHE_OFFSET_BITS-1:0] offset;
    logic [1:0]                     half_index;
    logic                           word_index;

    assign store_line_tag = store_addr[31:`DCACHE_OFFSET_BITS];

    assign offset     = store_addr[`DCACHE_OFFSET_BITS-1:0];
    assign half_index = offset[2:1];
    assign word_index = offset[2];

    // Place the store data at its byte lane and flag the lanes it covers
    always_comb begin
        store_block   = '0;
        store_byte_en = '0;

        case (store_size)
            BYTE: begin
                store_block.bytes[offset] = store_data[7:0];
                store_byte_en[offset]     = 1'b1;
            end

            HALF: begin
                // Low address bit is ignored, halves sit on even lanes
                store_block.bytes[{half_index, 1'b0}] = store_data[7:0];
                store_block.bytes[{half_index, 1'b1}] = store_data[15:8];
                store_byte_en[{half_index, 1'b0}]     = 1'b1;
                store_byte_en[{half_index, 1'b1}]     = 1'b1;
            end

            default: begin
                // Store data is only 32 bits wide, so a double is stored as a word
                store_block.words[word_index] = store_data;
                store_byte_en = word_index ? 8'b1111_0000 : 8'b0000_1111;
            end
        endcase
    end

endmodule

// File: source/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    typedef logic [`DCACHE_TAG_BITS-1:0] line_tag_t;

    // One block seen as bytes, as words or as a single 64-bit value
    typedef union packed {
        logic [`DCACHE_BLOCK_BYTES-1:0][7:0] bytes;
        logic [1:0][31:0]                    words;
        logic [63:0]                         dword;
    } block_t;

    typedef logic [`DCACHE_BLOCK_BYTES-1:0] byte_en_t;

    typedef logic [`DCACHE_MEM_TAG_BITS-1:0] mem_tag_t;

    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_t;

    typedef struct packed {
        logic      valid;
        logic      dirty;
        line_tag_t tag;
        block_t    data;
    } cache_line_t;

    // Outstanding read, keyed by the tag memory handed back
    typedef struct packed {
        logic      valid;
        mem_tag_t  mem_tag;
        line_tag_t line_tag;
    } mshr_entry_t;

endpackage

// File: source/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Cache geometry
`define DCACHE_LINES        8
`define DCACHE_BLOCK_BYTES  8
`define DCACHE_OFFSET_BITS  3

// Line tag is address bits 31 down to the block offset
`define DCACHE_TAG_BITS     29

// Memory transaction tags, zero means no transaction
`define DCACHE_MEM_TAG_BITS 4

// Outstanding miss slots
`define DCACHE_MSHR_DEPTH   4

`endif
